// File: Bender.yml
package:
  name: mpmc_lite

sources:
  # Shared types first, then the blocks, then the top level
  - files:
      - source/mpmc_lite_pkg.sv
      - source/mpmc_port_arbiter.sv
      - source/mpmc_set_write_mask.sv
      - source/mpmc_ctrl_fsm.sv
      - source/mpmc_line_ram.sv
      - source/mpmc_lite_top.sv

  # Testbench, only for simulation
  - target: simulation
    files:
      - bench/mpmc_lite_tb.sv

// File: bench/mpmc_lite_tb.sv
`timescale 1ns/1ps

module mpmc_lite_tb;

	import mpmc_lite_pkg::*;

	localparam int DEPTH      = 64;
	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 4;
	localparam int N_PART     = 24;
	localparam int N_COLL     = 6;
	localparam int N_MIX      = 60;

	// The watchdog is sized from the number of accesses in all tests
	localparam int TOTAL_ACC  = 2 + 2 * DEPTH + 3 * N_PART + 2 * N_COLL + 2 * N_MIX;
	localparam int WATCHDOG_NS = (TOTAL_ACC * 3 * 4 + RST_CYCLES) * CLK_PERIOD;

	logic       clk;
	logic       arst_n;
	mpmc_req_t  port0_req;
	mpmc_req_t  port1_req;
	mpmc_resp_t port0_resp;
	mpmc_resp_t port1_resp;

	// Reference copy of the line memory that is updated in ack order
	logic [LINE_BITS-1:0] ref_mem [DEPTH];

	// Outstanding request of each port until the compare process sees its ack
	mpmc_req_t  pend_req [2];
	logic       pend_valid [2];

	// Ports in the order their acks arrived
	int         ack_log [$];

	logic [31:0] rng;
	logic        rr_next;
	int          err_count;
	int          tests_passed;
	int          tests_failed;
	int          errs_start;
	int          lat0;
	int          lat1;
	mpmc_req_t   r0;
	mpmc_req_t   r1;

	mpmc_lite_top #(.DEPTH(DEPTH)) UUT
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.port0_req  (port0_req),
		.port1_req  (port1_req),
		.port0_resp (port0_resp),
		.port1_resp (port1_resp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ============================================================
	// Stimulus helpers
	// ============================================================

	// Xorshift generator that returns one 32-bit word per call
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng = x;
		return x;
	endfunction

	function automatic logic [LINE_BITS-1:0] rand_line();
		logic [LINE_BITS-1:0] v;
		int k;
		for (k = 0; k < LINE_BITS / 32; k++)
			v[32*k +: 32] = next_rand();
		return v;
	endfunction

	// A read carries a full select, which the controller ignores anyway
	function automatic mpmc_req_t random_req(input logic we);
		mpmc_req_t r;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we  = we;
		r.sel = we ? LINE_BYTES'(next_rand()) : '1;
		r.adr = next_rand();
		r.dat = rand_line();
		return r;
	endfunction

	// Line index of a byte address with the offset dropped and wrapped at DEPTH
	function automatic int line_of(input logic [31:0] adr);
		return int'((adr >> 4) % DEPTH);
	endfunction

	// Expected line after an access where a write replaces each selected byte
	function automatic logic [LINE_BITS-1:0] ref_line(input logic [LINE_BITS-1:0] old,
		input mpmc_req_t r);
		logic [LINE_BITS-1:0] res;
		int b;
		res = old;
		if (r.we)
		begin
			for (b = 0; b < LINE_BYTES; b++)
			begin
				if (r.sel[b])
					res[8*b +: 8] = r.dat[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic ack_of(input int p);
		return (p == 0) ? port0_resp.ack : port1_resp.ack;
	endfunction

	// Starts on a rising edge and returns on the edge one cycle after the port drops stb
	// lat counts the edges from driving the request to seeing the ack
	task automatic issue(input int p, input mpmc_req_t r, output int lat);
		lat = 0;
		pend_req[p]   = r;
		pend_valid[p] = 1'b1;
		if (p == 0)
			port0_req <= r;
		else
			port1_req <= r;
		do
		begin
			@(posedge clk);
			lat++;
		end
		while (ack_of(p) !== 1'b1);
		if (p == 0)
			port0_req <= '0;
		else
			port1_req <= '0;
		@(posedge clk);
	endtask

	// A random mix of reads and writes with idle gaps of up to three cycles
	task automatic run_random(input int p, input int n);
		mpmc_req_t r;
		logic [31:0] w;
		int lat;
		int i;
		for (i = 0; i < n; i++)
		begin
			w = next_rand();
			repeat (w[1:0]) @(posedge clk);
			r = random_req(w[2]);
			issue(p, r, lat);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_count == errs_before)
		begin
			$display("PASS  %s", name);
			tests_passed++;
		end
		else
		begin
			$display("FAIL  %s  (%0d errors)", name, err_count - errs_before);
			tests_failed++;
		end
	endtask

	// ============================================================
	// Compare process
	// ============================================================

	task automatic check_ack(input int p, input mpmc_resp_t resp);
		logic [LINE_BITS-1:0] exp;
		int idx;
		if (resp.ack === 1'b1)
		begin
			ack_log.push_back(p);
			assert (pend_valid[p]) else
			begin
				$display("Error at %0t: port%0d was acked with no request pending", $time, p);
				err_count++;
			end
			if (pend_valid[p])
			begin
				idx = line_of(pend_req[p].adr);
				exp = ref_line(ref_mem[idx], pend_req[p]);
				// Writes update the model and reads are compared against it
				if (pend_req[p].we)
					ref_mem[idx] = exp;
				else
					assert (resp.dat === exp) else
					begin
						$display("MISMATCH at %0t: port%0d_resp.dat expected %h actual %h",
							$time, p, exp, resp.dat);
						err_count++;
					end
				pend_valid[p] = 1'b0;
			end
		end
	endtask

	// Acks are sampled on the edge that ends the response cycle
	always @(posedge clk)
	begin
		if (arst_n === 1'b1)
		begin
			check_ack(0, port0_resp);
			check_ack(1, port1_resp);
		end
	end

	// Ends a run that has stalled somewhere
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout at %0t: the tests did not finish in time", $time);
		$display("Simulation failed");
		$finish;
	end

	// ============================================================
	// Test sequence
	// ============================================================

	initial
	begin
		clk           = 1'b0;
		arst_n        = 1'b0;
		port0_req     = '0;
		port1_req     = '0;
		pend_valid[0] = 1'b0;
		pend_valid[1] = 1'b0;
		rng           = 32'h3f8c460d;
		rr_next       = 1'b0;
		err_count     = 0;
		tests_passed  = 0;
		tests_failed  = 0;
		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1;

		// Test 1 checks a quiet bus after reset
		errs_start = err_count;
		repeat (6)
		begin
			@(posedge clk);
			assert (port0_resp.ack === 1'b0 && port1_resp.ack === 1'b0) else
			begin
				$display("Error at %0t: an ack rose with no request on the bus", $time);
				err_count++;
			end
		end
		report_test("ack idle after reset", errs_start);

		// Test 2 times a lone write and read whose ack comes two edges after the latch edge
		errs_start = err_count;
		r0 = random_req(1'b1);
		r0.sel = '1;
		issue(0, r0, lat0);
		r0.we = 1'b0;
		issue(0, r0, lat1);
		assert (lat0 == 3 && lat1 == 3) else
		begin
			$display("MISMATCH at %0t: port0_resp.ack latency expected 2/2 actual %0d/%0d",
				$time, lat0 - 1, lat1 - 1);
			err_count++;
		end
		report_test("single access latency", errs_start);

		// Test 3 writes full lines from port 0 and reads them back from port 1
		errs_start = err_count;
		for (int i = 0; i < DEPTH; i++)
		begin
			r0 = random_req(1'b1);
			r0.sel = '1;
			r0.adr = i << 4;
			issue(0, r0, lat0);
		end
		for (int i = 0; i < DEPTH; i++)
		begin
			r1 = random_req(1'b0);
			r1.adr = i << 4;
			issue(1, r1, lat1);
		end
		report_test("full line write and read back", errs_start);

		// Test 4 makes partial writes and reads each line twice to show reads leave it intact
		errs_start = err_count;
		for (int i = 0; i < N_PART; i++)
		begin
			r0 = random_req(1'b1);
			issue(0, r0, lat0);
			r1 = r0;
			r1.we = 1'b0;
			issue(1, r1, lat1);
			issue(0, r1, lat0);
		end
		report_test("partial byte writes", errs_start);

		// Test 5 raises both ports in the same idle cycle with round robin starting at port 0
		errs_start = err_count;
		for (int i = 0; i < N_COLL; i++)
		begin
			ack_log.delete();
			r0 = random_req(i[0]);
			r1 = random_req(~i[0]);
			fork
				issue(0, r0, lat0);
				issue(1, r1, lat1);
			join
			assert (ack_log.size() == 2 && ack_log[0] == int'(rr_next)
				&& ack_log[1] != int'(rr_next)) else
			begin
				$display("Error at %0t: collision %0d did not ack port%0d first and then the other",
					$time, i, rr_next);
				err_count++;
			end
			rr_next = ~rr_next;
		end
		report_test("round-robin collisions", errs_start);

		// Test 6 runs long random traffic from both ports at once
		errs_start = err_count;
		fork
			run_random(0, N_MIX);
			run_random(1, N_MIX);
		join
		report_test("random mixed traffic", errs_start);

		$display("Tests passed: %0d  failed: %0d  errors: %0d",
			tests_passed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: mpmc_lite.f
source/mpmc_lite_pkg.sv
source/mpmc_port_arbiter.sv
source/mpmc_set_write_mask.sv
source/mpmc_ctrl_fsm.sv
source/mpmc_line_ram.sv
source/mpmc_lite_top.sv
bench/mpmc_lite_tb.sv

// File: source/mpmc_ctrl_fsm.sv
`timescale 1ns/1ps

module mpmc_ctrl_fsm
(
	input  logic                                clk,
	input  logic                                arst_n,
	input  mpmc_lite_pkg::mpmc_req_t             sel_req,
	input  logic                                grant,
	input  logic [mpmc_lite_pkg::LINE_BITS-1:0] rd_line,
	output mpmc_lite_pkg::mpmc_state_t           state,
	output logic                                mem_wr,
	output logic                                mem_rd,
	output mpmc_lite_pkg::mpmc_resp_t            port0_resp,
	output mpmc_lite_pkg::mpmc_resp_t            port1_resp
);

	import mpmc_lite_pkg::*;

	mpmc_state_t state_nxt;

	// The granted request is live while cycle and strobe are both up
	logic        req_go;

	// High for the single response cycle
	logic        responding;

	// ============================================================
	// State register
	// ============================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	assign req_go = sel_req.cyc & sel_req.stb;

	// Each access takes exactly three cycles
	// One idle cycle to grant, one to touch the memory, one to answer
	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
			begin
				if (req_go)
					state_nxt = ACCESS;
			end
			ACCESS:
			begin
				state_nxt = RESPOND;
			end
			RESPOND:
			begin
				// The port drops its strobe on this same edge
				state_nxt = IDLE;
			end
			default:
			begin
				state_nxt = IDLE;
			end
		endcase
	end

	// ============================================================
	// Memory strobes
	// ============================================================

	// The memory acts on the edge that ends the ACCESS cycle
	assign mem_wr = (state == ACCESS) &  sel_req.we;
	assign mem_rd = (state == ACCESS) & ~sel_req.we;

	// ============================================================
	// Port responses
	// ============================================================

	assign responding = (state == RESPOND);

	// Only the granted port sees the ack
	assign port0_resp.ack = responding & ~grant;
	assign port1_resp.ack = responding &  grant;

	// The registered read line is valid throughout RESPOND
	// After a write it simply carries stale data that the port ignores
	assign port0_resp.dat = rd_line;
	assign port1_resp.dat = rd_line;

	// An ack only answers a request that its port still holds up
	assert property (@(posedge clk) disable iff (!arst_n)
		(port0_resp.ack || port1_resp.ack) |-> (sel_req.cyc && sel_req.stb));

	// The request that the memory saw is the one being answered
	assert property (@(posedge clk) disable iff (!arst_n)
		(port0_resp.ack || port1_resp.ack) |-> $stable(sel_req));

endmodule

// File: source/mpmc_line_ram.sv
`timescale 1ns/1ps

module mpmc_line_ram
#(
	parameter int LINE_BYTES = mpmc_lite_pkg::LINE_BYTES,
	parameter int DEPTH      = 64
)
(
	input  logic                    clk,
	input  logic                    wr,
	input  logic                    rd,
	input  logic [31:0]             adr,
	input  logic [LINE_BYTES-1:0]   mask,
	input  logic [8*LINE_BYTES-1:0] wdat,
	output logic [8*LINE_BYTES-1:0] rdat
);

	// Byte offset bits inside one line
	localparam int OFS = $clog2(LINE_BYTES);

	// Width of the line index
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// One entry per line, split into byte lanes for the mask
	logic [LINE_BYTES-1:0][7:0] mem [DEPTH];

	logic [AW-1:0]              line_idx;

	// ============================================================
	// Line addressing
	// ============================================================

	// The byte offset is dropped and the line number wraps at DEPTH
	assign line_idx = AW'((adr >> OFS) % DEPTH);

	// ============================================================
	// Write and read ports
	// ============================================================

	// Masked writes and registered reads share the same line index
	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			// A zero mask bit lets that byte lane take the new data
			for (int b = 0; b < LINE_BYTES; b++)
			begin
				if (!mask[b])
					mem[line_idx][b] <= wdat[8*b +: 8];
			end
		end
		// Read data appears one edge after the strobe
		if (rd)
			rdat <= mem[line_idx];
	end

endmodule

// File: source/mpmc_lite_pkg.sv
package mpmc_lite_pkg;

	// ============================================================
	// Size constants
	// ============================================================

	// Bytes in one memory line, matching the wide DRAM word
	localparam int LINE_BYTES = 16;

	// Bits in one memory line
	localparam int LINE_BITS = 8 * LINE_BYTES;

	// ============================================================
	// Controller states
	// ============================================================

	// The controller steps every access through these three states
	// IDLE waits for a granted request and lets the mask register track it
	// ACCESS strobes the line memory for exactly one cycle
	// RESPOND returns the ack and the read line for exactly one cycle
	typedef enum logic [1:0]
	{
		IDLE    = 2'd0,
		ACCESS  = 2'd1,
		RESPOND = 2'd2
	} mpmc_state_t;

	// ============================================================
	// Bus port structs
	// ============================================================

	// One request from a bus port
	// Cycle and strobe rise together and stay up until the ack is seen
	// The byte select picks the bytes of the line that a write updates
	typedef struct packed
	{
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [LINE_BYTES-1:0] sel;
		logic [31:0]           adr;
		logic [LINE_BITS-1:0]  dat;
	} mpmc_req_t;

	// One response to a bus port
	// The ack is a single-cycle pulse and the data is valid with it
	typedef struct packed
	{
		logic                 ack;
		logic [LINE_BITS-1:0] dat;
	} mpmc_resp_t;

endpackage

// File: source/mpmc_lite_top.sv
`timescale 1ns/1ps

module mpmc_lite_top
#(
	parameter int LINE_BYTES = mpmc_lite_pkg::LINE_BYTES,
	parameter int DEPTH      = 64
)
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  mpmc_lite_pkg::mpmc_req_t  port0_req,
	input  mpmc_lite_pkg::mpmc_req_t  port1_req,
	output mpmc_lite_pkg::mpmc_resp_t port0_resp,
	output mpmc_lite_pkg::mpmc_resp_t port1_resp
);

	import mpmc_lite_pkg::*;

	// ============================================================
	// Internal wiring
	// ============================================================

	// Controller state shared by the arbiter and the mask register
	mpmc_state_t             state;

	// Request presented to the controller and the memory, and its port
	mpmc_req_t               sel_req;
	logic                    grant;

	// Active-low byte mask held for the access
	logic [LINE_BYTES-1:0]   mask;

	// Memory strobes from the controller
	logic                    mem_wr;
	logic                    mem_rd;

	// Registered line returned by the memory
	logic [8*LINE_BYTES-1:0] rd_line;

	// ============================================================
	// Blocks
	// ============================================================

	// Picks one port per access and freezes its request
	mpmc_port_arbiter u_arbiter
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.state     (state),
		.port0_req (port0_req),
		.port1_req (port1_req),
		.sel_req   (sel_req),
		.grant     (grant)
	);

	// Builds the DRAM byte mask while the controller waits
	mpmc_set_write_mask #(.LINE_BYTES(LINE_BYTES)) u_mask
	(
		.clk    (clk),
		.arst_n (arst_n),
		.state  (state),
		.we     (sel_req.we),
		.sel    (sel_req.sel),
		.mask   (mask)
	);

	// Sequences the access and answers the granted port
	mpmc_ctrl_fsm u_ctrl
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.sel_req    (sel_req),
		.grant      (grant),
		.rd_line    (rd_line),
		.state      (state),
		.mem_wr     (mem_wr),
		.mem_rd     (mem_rd),
		.port0_resp (port0_resp),
		.port1_resp (port1_resp)
	);

	// Stands in for the external DRAM
	mpmc_line_ram #(.LINE_BYTES(LINE_BYTES), .DEPTH(DEPTH)) u_ram
	(
		.clk  (clk),
		.wr   (mem_wr),
		.rd   (mem_rd),
		.adr  (sel_req.adr),
		.mask (mask),
		.wdat (sel_req.dat),
		.rdat (rd_line)
	);

endmodule

// File: source/mpmc_port_arbiter.sv
`timescale 1ns/1ps

module mpmc_port_arbiter
(
	input  logic                      clk,
	input  logic                      arst_n,
	input  mpmc_lite_pkg::mpmc_state_t state,
	input  mpmc_lite_pkg::mpmc_req_t   port0_req,
	input  mpmc_lite_pkg::mpmc_req_t   port1_req,
	output mpmc_lite_pkg::mpmc_req_t   sel_req,
	output logic                      grant
);

	import mpmc_lite_pkg::*;

	// A port is requesting while it holds both cycle and strobe high
	logic      req0;
	logic      req1;
	logic      both;

	// Combinational winner, valid while the controller is idle
	logic      win;
	mpmc_req_t win_req;

	// Round-robin pointer naming the port that wins the next collision
	logic      ptr;

	// Request and index captured on the edge that leaves IDLE
	logic      lat_grant;
	mpmc_req_t lat_req;

	// ============================================================
	// Winner selection
	// ============================================================

	assign req0 = port0_req.cyc & port0_req.stb;
	assign req1 = port1_req.cyc & port1_req.stb;
	assign both = req0 & req1;

	// On a collision the pointer decides, otherwise a lone port 1 wins
	// With no request at all port 0 is shown, whose strobe is low
	assign win     = both ? ptr : req1;
	assign win_req = win ? port1_req : port0_req;

	// ============================================================
	// Grant latch
	// ============================================================

	// The controller leaves IDLE on any edge where the winner is requesting
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ptr       <= 1'b0;
			lat_grant <= 1'b0;
		end
		else if (state == IDLE && (req0 | req1))
		begin
			lat_grant <= win;
			// Only a collision hands the priority to the other port
			if (both)
				ptr <= ~win;
		end
	end

	// The winning request is captured on the same edge as its index
	always_ff @(posedge clk)
	begin
		if (state == IDLE && (req0 | req1))
			lat_req <= win_req;
	end

	// In IDLE the controller and mask see the live winner
	// During the access the memory sees fields that cannot move
	assign sel_req = (state == IDLE) ? win_req : lat_req;
	assign grant   = (state == IDLE) ? win : lat_grant;

	// The granted port stays fixed from the latch edge until the ack
	assert property (@(posedge clk) disable iff (!arst_n)
		(state != IDLE) |-> $stable(grant));

endmodule

// File: source/mpmc_set_write_mask.sv
`timescale 1ns/1ps

module mpmc_set_write_mask
#(
	parameter int LINE_BYTES = mpmc_lite_pkg::LINE_BYTES
)
(
	input  logic                      clk,
	input  logic                      arst_n,
	input  mpmc_lite_pkg::mpmc_state_t state,
	input  logic                      we,
	input  logic [LINE_BYTES-1:0]     sel,
	output logic [LINE_BYTES-1:0]     mask
);

	import mpmc_lite_pkg::*;

	// ============================================================
	// Active-low byte mask
	// ============================================================

	// A zero bit lets the matching byte lane through to the DRAM
	// The register follows the arbiter winner on every idle edge
	// so the value taken on the grant edge is the one held for the access
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			mask <= '0;
		else if (state == IDLE)
		begin
			// A write touches only the selected bytes
			if (we)
				mask <= ~sel;
			// A read takes every byte of the line
			else
				mask <= '0;
		end
	end

	// Outside IDLE the value holds, which keeps the mask steady for the memory

	// A read that was latched by the arbiter must reach the memory unmasked
	assert property (@(posedge clk) disable iff (!arst_n)
		(state == ACCESS && !we) |-> (mask == '0));

endmodule
